//--- i2c_sender_pkg.sv
`default_nettype none

package i2c_sender_pkg;

    // system bus address is {block select, register offset}
    typedef logic [7:0] sb_addr_t;
    typedef logic [7:0] sb_data_t;

    typedef enum logic [3:0] {
        reg_cr1   = 4'd1,
        reg_brlsb = 4'd2,
        reg_brmsb = 4'd3,
        reg_irqen = 4'd5,
        reg_cmdr  = 4'd7,
        reg_txdr  = 4'd8,
        reg_sr    = 4'd11
    } sb_reg_e;

    // status register bits
    localparam sb_data_t sr_busy_mask  = 8'b0100_0000;
    localparam sb_data_t sr_trrdy_mask = 8'b0000_0100;
    localparam sb_data_t sr_nack_mask  = 8'b0000_0010;

    // command register values
    localparam sb_data_t cmdr_start_write = 8'h94;
    localparam sb_data_t cmdr_stop        = 8'h44;

    localparam int num_setup_regs = 4;
    localparam int num_xfers      = 4;
    localparam int bytes_per_xfer = 3;

    typedef enum logic [3:0] {
        seq_setup,
        seq_wait_idle,
        seq_write_txdr,
        seq_write_cmdr,
        seq_wait_trrdy,
        seq_stop,
        seq_stop_nack,
        seq_done,
        seq_error
    } seq_state_e;

    typedef enum logic [1:0] {
        bus_idle,
        bus_setup,
        bus_strobe,
        bus_ack
    } bus_state_e;

endpackage

`default_nettype wire

//--- wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_if import i2c_sender_pkg::*; ();

    logic     cyc;
    logic     stb;
    logic     we;
    sb_addr_t adr;
    sb_data_t dat_w;
    sb_data_t dat_r;
    logic     ack;

    modport initiator (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport target (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

//--- i2c_xfer_table.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_xfer_table import i2c_sender_pkg::*; (
    input  logic [1:0] setup_index,
    input  logic [1:0] xfer_index,
    input  logic [1:0] byte_index,
    output sb_reg_e    setup_reg,
    output sb_data_t   setup_data,
    output sb_data_t   tx_byte
);

    // setup list, written once after reset
    always_comb begin
        case (setup_index)
            2'd0: begin
                setup_reg  = reg_cr1;
                setup_data = 8'h80;
            end
            2'd1: begin
                setup_reg  = reg_brlsb;
                setup_data = 8'd120;
            end
            2'd2: begin
                setup_reg  = reg_brmsb;
                setup_data = 8'd0;
            end
            default: begin
                setup_reg  = reg_irqen;
                setup_data = 8'h06;
            end
        endcase
    end

    // payload of transfer i is 0x46, i, i*i
    always_comb begin
        case (byte_index)
            2'd0:    tx_byte = 8'h46;
            2'd1:    tx_byte = sb_data_t'(xfer_index);
            2'd2:    tx_byte = sb_data_t'(xfer_index) * sb_data_t'(xfer_index);
            default: tx_byte = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

//--- i2c_tx_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_tx_sequencer import i2c_sender_pkg::*; #(
    parameter logic [3:0] block_select = 4'd1
) (
    input  logic       clock,
    input  logic       reset,
    input  sb_reg_e    setup_reg,
    input  sb_data_t   setup_data,
    input  sb_data_t   tx_byte,
    output logic [1:0] setup_index,
    output logic [1:0] xfer_index,
    output logic [1:0] byte_index,
    output logic       done,
    output logic       error,
    wb_if.initiator    bus
);

    seq_state_e state;
    seq_state_e state_next;
    logic [1:0] setup_next;
    logic [1:0] xfer_next;
    logic [1:0] byte_next;
    logic       running_next;
    logic       req_we;
    sb_reg_e    req_reg;
    sb_data_t   req_data;

    // request fields only change with the state, so they hold until ack
    assign bus.we    = req_we;
    assign bus.adr   = sb_addr_t'({block_select, req_reg});
    assign bus.dat_w = req_data;

    assign running_next = (state_next != seq_done) && (state_next != seq_error);

    always_comb begin
        state_next = state;
        setup_next = setup_index;
        xfer_next  = xfer_index;
        byte_next  = byte_index;
        req_we     = 1'b0;
        req_reg    = reg_sr;
        req_data   = '0;
        case (state)
            seq_setup: begin
                req_we   = 1'b1;
                req_reg  = setup_reg;
                req_data = setup_data;
                if (bus.ack) begin
                    if (setup_index == 2'(num_setup_regs - 1)) begin
                        state_next = seq_wait_idle;
                    end else begin
                        setup_next = setup_index + 2'd1;
                    end
                end
            end
            // SR read, keep polling while busy
            seq_wait_idle: begin
                if (bus.ack && (bus.dat_r & sr_busy_mask) == '0) begin
                    state_next = seq_write_txdr;
                end
            end
            seq_write_txdr: begin
                req_we   = 1'b1;
                req_reg  = reg_txdr;
                req_data = tx_byte;
                if (bus.ack) begin
                    state_next = seq_write_cmdr;
                end
            end
            seq_write_cmdr: begin
                req_we   = 1'b1;
                req_reg  = reg_cmdr;
                req_data = cmdr_start_write;
                if (bus.ack) begin
                    state_next = seq_wait_trrdy;
                end
            end
            seq_wait_trrdy: begin
                if (bus.ack) begin
                    if ((bus.dat_r & sr_nack_mask) != '0) begin
                        state_next = seq_stop_nack;
                    end else if ((bus.dat_r & sr_trrdy_mask) != '0) begin
                        if (byte_index == 2'(bytes_per_xfer - 1)) begin
                            byte_next  = 2'd0;
                            state_next = seq_stop;
                        end else begin
                            byte_next  = byte_index + 2'd1;
                            state_next = seq_write_txdr;
                        end
                    end
                end
            end
            seq_stop: begin
                req_we   = 1'b1;
                req_reg  = reg_cmdr;
                req_data = cmdr_stop;
                if (bus.ack) begin
                    if (xfer_index == 2'(num_xfers - 1)) begin
                        state_next = seq_done;
                    end else begin
                        xfer_next  = xfer_index + 2'd1;
                        state_next = seq_wait_idle;
                    end
                end
            end
            seq_stop_nack: begin
                req_we   = 1'b1;
                req_reg  = reg_cmdr;
                req_data = cmdr_stop;
                if (bus.ack) begin
                    state_next = seq_error;
                end
            end
            default: begin
                // done and error are terminal
                state_next = state;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state       <= seq_setup;
            setup_index <= 2'd0;
            xfer_index  <= 2'd0;
            byte_index  <= 2'd0;
            bus.cyc     <= 1'b0;
            bus.stb     <= 1'b0;
            done        <= 1'b0;
            error       <= 1'b0;
        end else begin
            state       <= state_next;
            setup_index <= setup_next;
            xfer_index  <= xfer_next;
            byte_index  <= byte_next;
            bus.cyc     <= running_next;
            // strobe drops for the cycle after each ack
            bus.stb     <= running_next && !bus.ack;
            done        <= (state_next == seq_done);
            error       <= (state_next == seq_error);
        end
    end

    stb_needs_cyc: assert property (@(posedge clock) disable iff (!reset)
        $rose(bus.stb) |-> bus.cyc)
        else $error("stb raised outside a bus cycle");

    done_error_exclusive: assert property (@(posedge clock) disable iff (!reset)
        !(done && error))
        else $error("done and error both high");

endmodule

`default_nettype wire

//--- sys_bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module sys_bus_master import i2c_sender_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  sb_data_t sbdat_from_ip,
    input  logic     sback,
    output logic     sbclk,
    output logic     sbrw,
    output logic     sbstb,
    output sb_addr_t sbadr,
    output sb_data_t sbdat_to_ip,
    wb_if.target     bus
);

    bus_state_e state;

    // the IP runs off the same clock
    assign sbclk   = clock;
    assign sbstb   = (state == bus_strobe);
    assign bus.ack = (state == bus_ack);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= bus_idle;
        end else begin
            case (state)
                bus_idle: begin
                    if (bus.cyc && bus.stb) begin
                        state <= bus_setup;
                    end
                end
                bus_setup: begin
                    state <= bus_strobe;
                end
                bus_strobe: begin
                    if (sback) begin
                        state <= bus_ack;
                    end
                end
                default: begin
                    // stb from the initiator is ignored here
                    state <= bus_idle;
                end
            endcase
        end
    end

    // latched request, held for the whole strobe
    always_ff @(posedge clock) begin
        if (state == bus_idle && bus.cyc && bus.stb) begin
            sbrw        <= bus.we;
            sbadr       <= bus.adr;
            sbdat_to_ip <= bus.dat_w;
        end
        if (state == bus_strobe && sback) begin
            bus.dat_r <= sbrw ? '0 : sbdat_from_ip;
        end
    end

    sb_request_stable: assert property (@(posedge clock) disable iff (!reset)
        sbstb ##1 sbstb |-> $stable(sbadr) && $stable(sbrw))
        else $error("system bus request changed during strobe");

    ack_single_cycle: assert property (@(posedge clock) disable iff (!reset)
        bus.ack |=> !bus.ack)
        else $error("ack held longer than one cycle");

endmodule

`default_nettype wire

//--- i2c_sender_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_sender_top import i2c_sender_pkg::*; #(
    parameter logic [3:0] block_select = 4'd1
) (
    input  logic     clock,
    input  logic     reset,
    input  sb_data_t sbdat_from_ip,
    input  logic     sback,
    output logic     sbclk,
    output logic     sbrw,
    output logic     sbstb,
    output sb_addr_t sbadr,
    output sb_data_t sbdat_to_ip,
    output logic     done,
    output logic     error
);

    logic [1:0] setup_index;
    logic [1:0] xfer_index;
    logic [1:0] byte_index;
    sb_reg_e    setup_reg;
    sb_data_t   setup_data;
    sb_data_t   tx_byte;

    wb_if seq_bus ();

    i2c_xfer_table u_table (
        .setup_index (setup_index),
        .xfer_index  (xfer_index),
        .byte_index  (byte_index),
        .setup_reg   (setup_reg),
        .setup_data  (setup_data),
        .tx_byte     (tx_byte)
    );

    i2c_tx_sequencer #(
        .block_select (block_select)
    ) u_seq (
        .clock       (clock),
        .reset       (reset),
        .setup_reg   (setup_reg),
        .setup_data  (setup_data),
        .tx_byte     (tx_byte),
        .setup_index (setup_index),
        .xfer_index  (xfer_index),
        .byte_index  (byte_index),
        .done        (done),
        .error       (error),
        .bus         (seq_bus.initiator)
    );

    sys_bus_master u_master (
        .clock         (clock),
        .reset         (reset),
        .sbdat_from_ip (sbdat_from_ip),
        .sback         (sback),
        .sbclk         (sbclk),
        .sbrw          (sbrw),
        .sbstb         (sbstb),
        .sbadr         (sbadr),
        .sbdat_to_ip   (sbdat_to_ip),
        .bus           (seq_bus.target)
    );

endmodule

`default_nettype wire

//--- tb_i2c_sender.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_sender;

    localparam logic [3:0] block_select = 4'd1;
    // two runs of up to 150 accesses at 8 cycles worst case, plus reset and margin
    localparam int timeout_cycles = 2 * 150 * 8 + 1600;

    // register offsets and status bits of the I2C block
    localparam int off_cr1   = 1;
    localparam int off_brlsb = 2;
    localparam int off_brmsb = 3;
    localparam int off_irqen = 5;
    localparam int off_cmdr  = 7;
    localparam int off_txdr  = 8;
    localparam int off_sr    = 11;
    localparam logic [7:0] busy_bit  = 8'h40;
    localparam logic [7:0] trrdy_bit = 8'h04;
    localparam logic [7:0] nack_bit  = 8'h02;

    localparam int kind_write      = 0;
    localparam int kind_poll_idle  = 1;
    localparam int kind_poll_trrdy = 2;

    logic       clock = 1'b0;
    logic       reset;
    logic [7:0] sbdat_from_ip;
    logic       sback;
    logic       sbclk;
    logic       sbrw;
    logic       sbstb;
    logic [7:0] sbadr;
    logic [7:0] sbdat_to_ip;
    logic       done;
    logic       error;

    integer     seed = 59813;
    int         error_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;

    // expected access list
    int         exp_kind [0:63];
    logic [7:0] exp_adr [0:63];
    logic [7:0] exp_data [0:63];
    int         n_exp;
    int         nack_pos;
    int         pos;
    logic       finished;
    logic       nack_run;
    logic       nack_stop_due;

    // responder and monitor state
    logic       pending;
    logic [1:0] delay_left;
    integer     delay_rnd;
    logic [7:0] resp_data;
    logic       prev_stb;
    logic       prev_rw;
    logic [7:0] prev_adr;
    logic [7:0] prev_wdata;
    logic       sback_seen;

    i2c_sender_top #(
        .block_select (block_select)
    ) u_dut (
        .clock         (clock),
        .reset         (reset),
        .sbdat_from_ip (sbdat_from_ip),
        .sback         (sback),
        .sbclk         (sbclk),
        .sbrw          (sbrw),
        .sbstb         (sbstb),
        .sbadr         (sbadr),
        .sbdat_to_ip   (sbdat_to_ip),
        .done          (done),
        .error         (error)
    );

    always #2 clock = ~clock;

    task automatic log_mismatch(input string msg);
        error_count++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic log_problem(input string msg);
        error_count++;
        $display("problem at %0t ns: %s", $time, msg);
    endtask

    task automatic add_entry(input int kind, input int offset, input logic [7:0] data);
        exp_kind[n_exp] = kind;
        exp_adr[n_exp]  = block_select * 16 + offset;
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    task automatic build_expected();
        logic [7:0] payload;
        n_exp = 0;
        add_entry(kind_write, off_cr1, 8'h80);
        add_entry(kind_write, off_brlsb, 8'd120);
        add_entry(kind_write, off_brmsb, 8'd0);
        add_entry(kind_write, off_irqen, 8'h06);
        for (int x = 0; x < 4; x++) begin
            add_entry(kind_poll_idle, off_sr, 8'h00);
            for (int b = 0; b < 3; b++) begin
                payload = (b == 0) ? 8'h46 : (b == 1) ? x : x * x;
                add_entry(kind_write, off_txdr, payload);
                add_entry(kind_write, off_cmdr, 8'h94);
                // second byte of transfer 1 gets the NACK in run two
                if (x == 1 && b == 1) begin
                    nack_pos = n_exp;
                end
                add_entry(kind_poll_trrdy, off_sr, 8'h00);
            end
            add_entry(kind_write, off_cmdr, 8'h44);
        end
    endtask

    task automatic start_run(input logic with_nack);
        pos           = 0;
        finished      = 1'b0;
        nack_run      = with_nack;
        nack_stop_due = 1'b0;
    endtask

    // matches one completed access and picks the read data for it
    task automatic check_access(input logic [7:0] adr, input logic rw,
                                input logic [7:0] wdata, output logic [7:0] rdata);
        integer     rnd;
        logic       hit;
        logic [7:0] noise;
        rnd   = $random(seed);
        noise = rnd[7:0];
        rdata = noise;
        hit   = ($random(seed) % 2) != 0;
        check_count++;
        if (finished) begin
            log_problem("bus access after the sequence had ended");
        end else if (nack_stop_due) begin
            if (rw !== 1'b1 || adr !== block_select * 16 + off_cmdr || wdata !== 8'h44) begin
                log_mismatch($sformatf(
                    "after NACK expected CMDR write 44, got adr %h rw %b data %h",
                    adr, rw, wdata));
            end
            nack_stop_due = 1'b0;
            finished      = 1'b1;
        end else if (exp_kind[pos] == kind_write) begin
            if (rw !== 1'b1 || adr !== exp_adr[pos] || wdata !== exp_data[pos]) begin
                log_mismatch($sformatf(
                    "access %0d expected write adr %h data %h, got adr %h rw %b data %h",
                    pos, exp_adr[pos], exp_data[pos], adr, rw, wdata));
            end
            pos++;
        end else if (rw !== 1'b0 || adr !== exp_adr[pos]) begin
            log_mismatch($sformatf("access %0d expected SR read, got adr %h rw %b data %h",
                pos, adr, rw, wdata));
        end else if (exp_kind[pos] == kind_poll_idle) begin
            rdata = (noise & ~(busy_bit | nack_bit)) | (hit ? busy_bit : 8'h00);
            if (!hit) begin
                pos++;
            end
        end else if (nack_run && pos == nack_pos) begin
            rdata         = noise | nack_bit;
            nack_stop_due = 1'b1;
        end else begin
            rdata = (noise & ~(trrdy_bit | nack_bit)) | (hit ? trrdy_bit : 8'h00);
            if (hit) begin
                pos++;
            end
        end
        if (pos == n_exp) begin
            finished = 1'b1;
        end
    endtask

    // system-bus responder with 0 to 3 cycles of wait
    always @(posedge clock) begin
        if (!reset) begin
            sback   <= 1'b0;
            pending = 1'b0;
        end else if (sback) begin
            sback   <= 1'b0;
            pending = 1'b0;
        end else if (sbstb === 1'b1) begin
            if (!pending) begin
                pending    = 1'b1;
                delay_rnd  = $random(seed);
                delay_left = delay_rnd[1:0];
            end
            if (delay_left == 2'd0) begin
                check_access(sbadr, sbrw, sbdat_to_ip, resp_data);
                sbdat_from_ip <= resp_data;
                sback         <= 1'b1;
            end else begin
                delay_left = delay_left - 2'd1;
            end
        end
    end

    // strobe protocol
    always @(posedge clock) begin
        if (!reset) begin
            prev_stb   <= 1'b0;
            sback_seen <= 1'b0;
        end else begin
            if (prev_stb && sbstb === 1'b1) begin
                if (sbadr !== prev_adr || sbrw !== prev_rw || sbdat_to_ip !== prev_wdata) begin
                    log_mismatch("request changed while sbstb high");
                end
            end
            if (sback_seen && sbstb === 1'b1) begin
                log_problem("sbstb still high one cycle after sback");
            end
            prev_stb   <= (sbstb === 1'b1);
            prev_adr   <= sbadr;
            prev_rw    <= sbrw;
            prev_wdata <= sbdat_to_ip;
            sback_seen <= sback;
        end
    end

    // sbclk follows the clock, sampled mid-phase
    always @(clock) begin
        #1;
        if (sbclk !== clock) begin
            log_mismatch($sformatf("sbclk is %b while clock is %b", sbclk, clock));
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("run did not finish within %0d cycles", timeout_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic apply_reset();
        @(posedge clock);
        reset <= 1'b0;
        repeat (8) @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);
    endtask

    task automatic wait_for_end();
        while (done !== 1'b1 && error !== 1'b1) begin
            @(posedge clock);
        end
    endtask

    task automatic check_flags(input logic with_nack);
        check_count++;
        if (!finished) begin
            log_problem("run ended before the expected accesses were complete");
        end
        if (done !== !with_nack || error !== with_nack) begin
            log_mismatch($sformatf("expected done %b error %b, got done %b error %b",
                !with_nack, with_nack, done, error));
        end
    endtask

    initial begin
        reset         = 1'b0;
        sback         = 1'b0;
        sbdat_from_ip = 8'h00;
        build_expected();

        // run one, no NACK
        start_run(1'b0);
        apply_reset();
        wait_for_end();
        check_flags(1'b0);
        repeat (20) @(posedge clock);
        check_flags(1'b0);

        // run two, NACK on transfer 1 byte 1
        start_run(1'b1);
        apply_reset();
        wait_for_end();
        check_flags(1'b1);
        repeat (20) @(posedge clock);
        check_flags(1'b1);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
i2c_sender_pkg.sv
wb_if.sv
i2c_xfer_table.sv
i2c_tx_sequencer.sv
sys_bus_master.sv
i2c_sender_top.sv
tb_i2c_sender.sv

//--- Bender.yml
package:
  name: i2c_sender

sources:
  - i2c_sender_pkg.sv
  - wb_if.sv
  - i2c_xfer_table.sv
  - i2c_tx_sequencer.sv
  - sys_bus_master.sv
  - i2c_sender_top.sv
  - target: simulation
    files:
      - tb_i2c_sender.sv
